// ==== rtl/cdr_config.svh ====
`ifndef CDR_CONFIG_SVH
`define CDR_CONFIG_SVH

// ADC side.
`define NADC            8   // Bits per sample.
`define NTI             4   // Interleaved samples per word.

// Interpolator side.
`define NPI             8   // Code width.
`define NOUT            4   // Lanes driven with the same code.

// Loop filter.
`define GAIN_WIDTH      3   // Shift gains.
`define PHASE_EST_SHIFT 8   // Fraction bits below the phase estimate.

// Cycles the loop stays quiet after reset release.
`define HOLD_CYCLES     32

`endif

// ==== rtl/cdr_pkg.sv ====
`include "cdr_config.svh"

package cdr_pkg;

    // Raw ADC sample.
    typedef logic signed [`NADC-1:0] adc_sample_t;

    // Detector output, two guard bits over a sample.
    typedef logic signed [`NADC+1:0] phase_err_t;

    // Loop accumulators, detector width plus fraction bits.
    typedef logic signed [`NADC+1+`PHASE_EST_SHIFT:0] loop_acc_t;

    typedef logic [`NPI-1:0] pi_code_t;

    typedef logic [`GAIN_WIDTH-1:0] gain_t;  // Left shift amount.

    // Debug snapshot FSM.
    typedef enum logic [1:0] {
        SAMPLER_WAIT,
        SAMPLER_READY,
        SAMPLER_SAMPLE
    } sampler_state_t;

endpackage

// ==== rtl/mm_pd.sv ====
`include "cdr_config.svh"
`default_nettype none

module mm_pd (
    input  wire cdr_pkg::adc_sample_t din_i [`NTI],
    input  wire cdr_pkg::phase_err_t  pd_offset_i,
    output cdr_pkg::phase_err_t       pd_error_o
);

    import cdr_pkg::*;

    // Room for NTI-1 terms of two samples each plus the offset.
    localparam int sum_w = `NADC + 4;

    localparam logic signed [sum_w-1:0] err_max = (1 <<< (`NADC + 1)) - 1;
    localparam logic signed [sum_w-1:0] err_min = -(1 <<< (`NADC + 1));

    logic signed [sum_w-1:0] pd_sum;

    // x[k]*sgn(x[k-1]) - x[k-1]*sgn(x[k]), zero counts as positive.
    function automatic logic signed [sum_w-1:0] mm_term(
        input adc_sample_t prev_smp,
        input adc_sample_t cur_smp
    );
        logic signed [sum_w-1:0] p;
        logic signed [sum_w-1:0] c;
        logic signed [sum_w-1:0] lead;
        logic signed [sum_w-1:0] lag;
        p = prev_smp;
        c = cur_smp;
        lead = prev_smp[`NADC-1] ? -c : c;
        lag  = cur_smp[`NADC-1] ? -p : p;
        return lead - lag;
    endfunction

    always_comb begin
        pd_sum = pd_offset_i;  // Sign extended.
        for (int k = 1; k < `NTI; k++) begin
            pd_sum = pd_sum + mm_term(din_i[k-1], din_i[k]);
        end
    end

    // Clamp to the error range.
    always_comb begin
        if (pd_sum > err_max) begin
            pd_error_o = phase_err_t'(err_max);
        end else if (pd_sum < err_min) begin
            pd_error_o = phase_err_t'(err_min);
        end else begin
            pd_error_o = phase_err_t'(pd_sum);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cdr_loop_filter.sv ====
`include "cdr_config.svh"
`default_nettype none

module cdr_loop_filter (
    input  wire logic                clk,
    input  wire logic                ext_rstb,
    input  wire cdr_pkg::phase_err_t pd_error_i,
    input  wire logic                ramp_clock_i,
    input  wire cdr_pkg::gain_t      kp_i,
    input  wire cdr_pkg::gain_t      ki_i,
    input  wire cdr_pkg::gain_t      kr_i,
    input  wire logic                en_freq_est_i,
    input  wire logic                en_ramp_est_i,
    input  wire logic                en_ext_pi_ctl_i,
    input  wire cdr_pkg::pi_code_t   ext_pi_ctl_i,
    output cdr_pkg::pi_code_t        pi_ctl_o [`NOUT],
    output logic                     freq_lvl_cross_o,
    output cdr_pkg::phase_err_t      phase_est_out_o,
    output cdr_pkg::loop_acc_t       freq_update_o,
    output cdr_pkg::loop_acc_t       ramp_update_o
);

    import cdr_pkg::*;

    localparam int hold_cnt_w = $clog2(`HOLD_CYCLES + 2);
    localparam int pi_shift   = `NADC + 2 - `NPI;  // Drop the low detector bits.

    logic [hold_cnt_w-1:0] hold_cnt;
    logic                  hold_done;

    logic ramp_clock_ff;
    logic ramp_sync;

    phase_err_t phase_error;
    loop_acc_t  err_ext;

    loop_acc_t phase_q;
    loop_acc_t phase_d;
    loop_acc_t freq_q;
    loop_acc_t freq_d;
    loop_acc_t freq_update;
    loop_acc_t prev_freq_update_q;

    loop_acc_t ramp_pls_q;
    loop_acc_t ramp_pls_d;
    loop_acc_t ramp_neg_q;
    loop_acc_t ramp_neg_d;
    loop_acc_t ramp_term;

    logic signed [`NADC+2+`PHASE_EST_SHIFT:0] freq_diff;  // One bit over loop_acc_t.

    pi_code_t pi_code;

    // Hold-off after reset. Runs once, then parks.
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            hold_cnt  <= '0;
            hold_done <= 1'b0;
        end else if (!hold_done) begin
            hold_cnt  <= hold_cnt + 1'b1;
            hold_done <= (hold_cnt == hold_cnt_w'(`HOLD_CYCLES));
        end
    end

    // Slow ramp clock into the clk domain.
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            ramp_clock_ff <= 1'b0;
            ramp_sync     <= 1'b0;
        end else begin
            ramp_clock_ff <= ramp_clock_i;
            ramp_sync     <= ramp_clock_ff;
        end
    end

    always_comb begin
        err_ext = phase_error;  // Sign extended.

        // Each half of the ramp period has its own accumulator.
        if (ramp_sync) begin
            ramp_pls_d = ramp_pls_q + (err_ext <<< kr_i);
            ramp_neg_d = ramp_neg_q;
        end else begin
            ramp_pls_d = ramp_pls_q;
            ramp_neg_d = ramp_neg_q + (err_ext <<< kr_i);
        end
        if (!en_ramp_est_i) begin
            ramp_pls_d = '0;
            ramp_neg_d = '0;
        end

        ramp_term   = ramp_sync ? ramp_pls_q : ramp_neg_q;
        freq_update = freq_q + (err_ext <<< ki_i) + ramp_term;
        freq_d      = en_freq_est_i ? freq_update : '0;
        phase_d     = phase_q + (err_ext <<< kp_i) + freq_q;
        freq_diff   = freq_update - prev_freq_update_q;
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            phase_error        <= '0;
            phase_q            <= '0;
            freq_q             <= '0;
            prev_freq_update_q <= '0;
            ramp_pls_q         <= '0;
            ramp_neg_q         <= '0;
        end else if (!hold_done) begin
            phase_error        <= '0;
            phase_q            <= '0;
            freq_q             <= '0;
            prev_freq_update_q <= '0;
            ramp_pls_q         <= '0;
            ramp_neg_q         <= '0;
        end else begin
            phase_error        <= pd_error_i;
            phase_q            <= phase_d;
            freq_q             <= freq_d;
            prev_freq_update_q <= freq_update;
            ramp_pls_q         <= ramp_pls_d;
            ramp_neg_q         <= ramp_neg_d;
        end
    end

    // Set when the frequency update moved up.
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            freq_lvl_cross_o <= 1'b0;
        end else begin
            freq_lvl_cross_o <= (freq_diff > 0);
        end
    end

    assign phase_est_out_o = phase_err_t'(phase_q >>> `PHASE_EST_SHIFT);
    assign pi_code         = pi_code_t'(phase_est_out_o >>> pi_shift);

    // Same code on every lane unless overridden.
    always_comb begin
        for (int k = 0; k < `NOUT; k++) begin
            pi_ctl_o[k] = en_ext_pi_ctl_i ? ext_pi_ctl_i : pi_code;
        end
    end

    assign freq_update_o = freq_update;
    assign ramp_update_o = ramp_sync ? ramp_pls_d : ramp_neg_d;

endmodule

`default_nettype wire

// ==== rtl/cdr_state_sampler.sv ====
`include "cdr_config.svh"
`default_nettype none

module cdr_state_sampler (
    input  wire logic                clk,
    input  wire logic                ext_rstb,
    input  wire logic                sample_req_i,
    input  wire cdr_pkg::phase_err_t phase_est_i,
    input  wire cdr_pkg::loop_acc_t  freq_est_i,
    input  wire cdr_pkg::loop_acc_t  ramp_est_i,
    output cdr_pkg::phase_err_t      snap_phase_o,
    output cdr_pkg::loop_acc_t       snap_freq_o,
    output cdr_pkg::loop_acc_t       snap_ramp_o
);

    import cdr_pkg::*;

    sampler_state_t state;
    sampler_state_t state_next;

    // Arm on a low request, fire on a high one.
    always_comb begin
        state_next = state;
        case (state)
            SAMPLER_WAIT: begin
                if (!sample_req_i) begin
                    state_next = SAMPLER_READY;
                end
            end
            SAMPLER_READY: begin
                if (sample_req_i) begin
                    state_next = SAMPLER_SAMPLE;
                end
            end
            SAMPLER_SAMPLE: state_next = SAMPLER_WAIT;  // One shot.
            default: state_next = SAMPLER_WAIT;
        endcase
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            state        <= SAMPLER_WAIT;
            snap_phase_o <= '0;
            snap_freq_o  <= '0;
            snap_ramp_o  <= '0;
        end else begin
            state <= state_next;
            if (state == SAMPLER_SAMPLE) begin
                snap_phase_o <= phase_est_i;
                snap_freq_o  <= freq_est_i;
                snap_ramp_o  <= ramp_est_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cdr_top.sv ====
`include "cdr_config.svh"
`default_nettype none

module cdr_top (
    input  wire logic                 clk,
    input  wire logic                 ext_rstb,
    input  wire cdr_pkg::adc_sample_t din_i [`NTI],
    input  wire cdr_pkg::phase_err_t  pd_offset_i,
    input  wire logic                 ramp_clock_i,
    input  wire cdr_pkg::gain_t       kp_i,
    input  wire cdr_pkg::gain_t       ki_i,
    input  wire cdr_pkg::gain_t       kr_i,
    input  wire logic                 en_freq_est_i,
    input  wire logic                 en_ramp_est_i,
    input  wire logic                 en_ext_pi_ctl_i,
    input  wire cdr_pkg::pi_code_t    ext_pi_ctl_i,
    input  wire logic                 sample_req_i,
    output cdr_pkg::pi_code_t         pi_ctl_o [`NOUT],
    output logic                      freq_lvl_cross_o,
    output cdr_pkg::phase_err_t       snap_phase_o,
    output cdr_pkg::loop_acc_t        snap_freq_o,
    output cdr_pkg::loop_acc_t        snap_ramp_o
);

    import cdr_pkg::*;

    phase_err_t pd_error;       // Combinational detector output.
    phase_err_t phase_est_out;
    loop_acc_t  freq_update;
    loop_acc_t  ramp_update;

    mm_pd pd0 (
        .din_i       (din_i),
        .pd_offset_i (pd_offset_i),
        .pd_error_o  (pd_error)
    );

    cdr_loop_filter lf0 (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .pd_error_i       (pd_error),
        .ramp_clock_i     (ramp_clock_i),
        .kp_i             (kp_i),
        .ki_i             (ki_i),
        .kr_i             (kr_i),
        .en_freq_est_i    (en_freq_est_i),
        .en_ramp_est_i    (en_ramp_est_i),
        .en_ext_pi_ctl_i  (en_ext_pi_ctl_i),
        .ext_pi_ctl_i     (ext_pi_ctl_i),
        .pi_ctl_o         (pi_ctl_o),
        .freq_lvl_cross_o (freq_lvl_cross_o),
        .phase_est_out_o  (phase_est_out),
        .freq_update_o    (freq_update),
        .ramp_update_o    (ramp_update)
    );

    // Debug snapshot of the loop state.
    cdr_state_sampler smp0 (
        .clk          (clk),
        .ext_rstb     (ext_rstb),
        .sample_req_i (sample_req_i),
        .phase_est_i  (phase_est_out),
        .freq_est_i   (freq_update),
        .ramp_est_i   (ramp_update),
        .snap_phase_o (snap_phase_o),
        .snap_freq_o  (snap_freq_o),
        .snap_ramp_o  (snap_ramp_o)
    );

endmodule

`default_nettype wire

// ==== test/cdr_tb.sv ====
`include "cdr_config.svh"

module cdr_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import cdr_pkg::*;

    logic        clk;
    logic        ext_rstb;
    adc_sample_t din [`NTI];
    phase_err_t  pd_offset;
    logic        ramp_clock;
    gain_t       kp;
    gain_t       ki;
    gain_t       kr;
    logic        en_freq;
    logic        en_ramp;
    logic        en_ext;
    pi_code_t    ext_pi;
    logic        sample_req;
    pi_code_t    pi_ctl [`NOUT];
    logic        lvl_cross;
    phase_err_t  snap_phase;
    loop_acc_t   snap_freq;
    loop_acc_t   snap_ramp;

    int check_count;
    int error_count;
    int test_count;

    // Reference model state.
    int             m_edges;  // Edges since reset release. Stops after the hold.
    int             m_err;
    loop_acc_t      m_phase;
    loop_acc_t      m_freq;
    loop_acc_t      m_prev_fu;
    loop_acc_t      m_rpos;
    loop_acc_t      m_rneg;
    logic           m_rclk_ff;
    logic           m_rsync;
    logic           m_cross;
    sampler_state_t m_sstate;
    phase_err_t     m_snap_phase;
    loop_acc_t      m_snap_freq;
    loop_acc_t      m_snap_ramp;
    int             m_snap_count;

    cdr_top dut0 (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .din_i            (din),
        .pd_offset_i      (pd_offset),
        .ramp_clock_i     (ramp_clock),
        .kp_i             (kp),
        .ki_i             (ki),
        .kr_i             (kr),
        .en_freq_est_i    (en_freq),
        .en_ramp_est_i    (en_ramp),
        .en_ext_pi_ctl_i  (en_ext),
        .ext_pi_ctl_i     (ext_pi),
        .sample_req_i     (sample_req),
        .pi_ctl_o         (pi_ctl),
        .freq_lvl_cross_o (lvl_cross),
        .snap_phase_o     (snap_phase),
        .snap_freq_o      (snap_freq),
        .snap_ramp_o      (snap_ramp)
    );

    always #2 clk = ~clk;

    // Mueller-Muller sum over the current word. Clamped to the error range.
    function automatic int expected_pd_error();
        int acc;
        int sgn_prev;
        int sgn_cur;
        acc = int'(pd_offset);
        for (int k = 1; k < `NTI; k++) begin
            sgn_prev = (din[k-1] < 0) ? -1 : 1;
            sgn_cur  = (din[k] < 0) ? -1 : 1;
            acc += int'(din[k]) * sgn_prev - int'(din[k-1]) * sgn_cur;
        end
        if (acc > (1 << (`NADC + 1)) - 1) begin
            acc = (1 << (`NADC + 1)) - 1;
        end else if (acc < -(1 << (`NADC + 1))) begin
            acc = -(1 << (`NADC + 1));
        end
        return acc;
    endfunction

    function automatic loop_acc_t scaled_error(input int e, input gain_t g);
        return loop_acc_t'(e * (1 << g));  // Wraps to accumulator width.
    endfunction

    function automatic pi_code_t expected_code();
        int est;
        if (en_ext) begin
            return ext_pi;
        end
        est = int'(m_phase) >>> `PHASE_EST_SHIFT;
        return pi_code_t'(est >>> 2);
    endfunction

    task automatic clear_loop_model();
        m_err     = 0;
        m_phase   = '0;
        m_freq    = '0;
        m_prev_fu = '0;
        m_rpos    = '0;
        m_rneg    = '0;
    endtask

    task automatic step_model();
        loop_acc_t  ramp_term;
        loop_acc_t  fu;
        loop_acc_t  rpos_d;
        loop_acc_t  rneg_d;
        loop_acc_t  ramp_upd;
        phase_err_t est;
        int         diff;
        if (!ext_rstb) begin
            clear_loop_model();
            m_edges      = 0;
            m_rclk_ff    = 1'b0;
            m_rsync      = 1'b0;
            m_cross      = 1'b0;
            m_sstate     = SAMPLER_WAIT;
            m_snap_phase = '0;
            m_snap_freq  = '0;
            m_snap_ramp  = '0;
            m_snap_count = 0;
        end else begin
            ramp_term = m_rsync ? m_rpos : m_rneg;
            fu        = m_freq + scaled_error(m_err, ki) + ramp_term;
            rpos_d    = m_rpos;
            rneg_d    = m_rneg;
            if (m_rsync) begin
                rpos_d = m_rpos + scaled_error(m_err, kr);
            end else begin
                rneg_d = m_rneg + scaled_error(m_err, kr);
            end
            if (!en_ramp) begin
                rpos_d = '0;
                rneg_d = '0;
            end
            ramp_upd = m_rsync ? rpos_d : rneg_d;
            est      = phase_err_t'(int'(m_phase) >>> `PHASE_EST_SHIFT);
            diff     = int'(fu) - int'(m_prev_fu);

            case (m_sstate)
                SAMPLER_WAIT: begin
                    if (!sample_req) begin
                        m_sstate = SAMPLER_READY;
                    end
                end
                SAMPLER_READY: begin
                    if (sample_req) begin
                        m_sstate = SAMPLER_SAMPLE;
                    end
                end
                default: begin
                    m_snap_phase = est;
                    m_snap_freq  = fu;
                    m_snap_ramp  = ramp_upd;
                    m_snap_count++;
                    m_sstate     = SAMPLER_WAIT;
                end
            endcase

            m_cross   = (diff > 0);
            m_rsync   = m_rclk_ff;
            m_rclk_ff = ramp_clock;

            if (m_edges < `HOLD_CYCLES + 1) begin
                m_edges++;
                clear_loop_model();
            end else begin
                m_phase   = m_phase + scaled_error(m_err, kp) + m_freq;  // Old frequency.
                m_freq    = en_freq ? fu : '0;
                m_prev_fu = fu;
                m_rpos    = rpos_d;
                m_rneg    = rneg_d;
                m_err     = expected_pd_error();
            end
        end
    endtask

    always @(posedge clk) begin
        step_model();
    end

    task automatic check_value(input string name, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch at %0d ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic compare_outputs();
        pi_code_t code;
        code = expected_code();
        for (int k = 0; k < `NOUT; k++) begin
            check_value($sformatf("pi_ctl_o[%0d]", k), code, pi_ctl[k]);
        end
        check_value("freq_lvl_cross_o", m_cross, lvl_cross);
    endtask

    task automatic wait_drive_slot();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_sample_point();
        #2;
    endtask

    task automatic drive_random_word();
        for (int k = 0; k < `NTI; k++) begin
            din[k] = adc_sample_t'($urandom);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic test_hold_off();
        int errs;
        errs = error_count;
        for (int i = 0; i < `HOLD_CYCLES; i++) begin
            wait_drive_slot();
            drive_random_word();
            din[0]    = adc_sample_t'(50);  // Never an all-zero word.
            pd_offset = phase_err_t'(100);
            kp        = 3'd3;
            wait_sample_point();
            for (int k = 0; k < `NOUT; k++) begin
                check_value($sformatf("pi_ctl_o[%0d]", k), 0, pi_ctl[k]);
            end
            check_value("freq_lvl_cross_o", 0, lvl_cross);
        end
        report_test("reset and hold-off", errs);
    endtask

    task automatic test_override();
        int errs;
        errs = error_count;
        for (int i = 0; i < 20; i++) begin
            wait_drive_slot();
            kp        = 3'd2;
            pd_offset = '0;
            drive_random_word();
            en_ext = 1'b1;
            ext_pi = pi_code_t'($urandom);
            wait_sample_point();
            for (int k = 0; k < `NOUT; k++) begin
                check_value($sformatf("pi_ctl_o[%0d]", k), ext_pi, pi_ctl[k]);
            end
        end
        for (int i = 0; i < 10; i++) begin
            wait_drive_slot();
            drive_random_word();
            en_ext = 1'b0;
            wait_sample_point();
            compare_outputs();
        end
        report_test("interpolator override", errs);
    endtask

    task automatic test_proportional();
        int errs;
        errs = error_count;
        for (int i = 0; i < 60; i++) begin
            wait_drive_slot();
            en_freq = 1'b0;
            en_ramp = 1'b0;
            drive_random_word();
            kp        = gain_t'($urandom);
            pd_offset = phase_err_t'($urandom);
            if (i % 4 == 0) begin
                pd_offset = (i % 8 == 0) ? phase_err_t'(511) : phase_err_t'(-512);  // Saturates.
            end
            wait_sample_point();
            compare_outputs();
        end
        report_test("detector and proportional path", errs);
    endtask

    task automatic test_frequency();
        int errs;
        errs = error_count;
        for (int i = 0; i < 60; i++) begin
            wait_drive_slot();
            en_freq = 1'b1;
            en_ramp = 1'b0;
            kp      = 3'd1;
            ki      = 3'd2;
            for (int k = 0; k < `NTI; k++) begin
                din[k] = '0;
            end
            pd_offset = (i < 30) ? phase_err_t'(24) : phase_err_t'(-24);
            wait_sample_point();
            compare_outputs();
        end
        report_test("frequency path", errs);
    endtask

    task automatic test_ramp();
        int errs;
        errs = error_count;
        for (int i = 0; i < 80; i++) begin
            wait_drive_slot();
            en_freq   = 1'b1;
            en_ramp   = 1'b1;
            kp        = 3'd1;
            ki        = 3'd0;
            kr        = 3'd1;
            pd_offset = '0;
            drive_random_word();
            if (i % 10 == 0) begin
                ramp_clock = ~ramp_clock;
            end
            wait_sample_point();
            compare_outputs();
        end
        report_test("ramp estimator", errs);
    endtask

    task automatic test_snapshot();
        int         errs;
        int         start_count;
        int         waited;
        phase_err_t exp_phase;
        loop_acc_t  exp_freq;
        loop_acc_t  exp_ramp;
        errs = error_count;
        for (int i = 0; i < 3; i++) begin
            wait_drive_slot();
            drive_random_word();
            sample_req = 1'b0;
        end
        start_count = m_snap_count;
        wait_drive_slot();
        drive_random_word();
        sample_req = 1'b1;
        waited = 0;
        while (m_snap_count == start_count && waited < 3) begin
            wait_drive_slot();
            drive_random_word();
            waited++;
        end
        if (m_snap_count == start_count) begin
            error_count++;
            $display("No snapshot was taken within 3 edges of the request at %0d ns", $time);
        end else begin
            wait_sample_point();
            exp_phase = m_snap_phase;
            exp_freq  = m_snap_freq;
            exp_ramp  = m_snap_ramp;
            check_value("snap_phase_o", exp_phase, snap_phase);
            check_value("snap_freq_o", exp_freq, snap_freq);
            check_value("snap_ramp_o", exp_ramp, snap_ramp);
            // Request stays high. The snapshot must hold.
            for (int i = 0; i < 8; i++) begin
                wait_drive_slot();
                drive_random_word();
                wait_sample_point();
                check_value("snap_phase_o", exp_phase, snap_phase);
                check_value("snap_freq_o", exp_freq, snap_freq);
                check_value("snap_ramp_o", exp_ramp, snap_ramp);
            end
        end
        report_test("state snapshot", errs);
    endtask

    initial begin
        void'($urandom(32'h51f3));
        clk         = 1'b0;
        ext_rstb    = 1'b0;
        pd_offset   = '0;
        ramp_clock  = 1'b0;
        kp          = '0;
        ki          = '0;
        kr          = '0;
        en_freq     = 1'b0;
        en_ramp     = 1'b0;
        en_ext      = 1'b0;
        ext_pi      = '0;
        sample_req  = 1'b0;
        check_count = 0;
        error_count = 0;
        test_count  = 0;
        for (int k = 0; k < `NTI; k++) begin
            din[k] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        ext_rstb = 1'b1;

        test_hold_off();
        test_override();
        test_proportional();
        test_frequency();
        test_ramp();
        test_snapshot();

        wait_drive_slot();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #20000;
        $display("Timeout: the tests did not finish within 20000 ns");
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+rtl
rtl/cdr_pkg.sv
rtl/mm_pd.sv
rtl/cdr_loop_filter.sv
rtl/cdr_state_sampler.sv
rtl/cdr_top.sv
test/cdr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CDR testbench, then scan the log for failures.
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary -Wno-fatal --top-module cdr_tb -f filelist.f -o cdr_sim \
    && ./obj_dir/cdr_sim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"
exit 0
